//--- Makefile
# Verilator build and run of the x86 register file testbench

TOP := x86_regfile_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f x86_regfile.f --Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

//--- rtl/apb_regfile_slave.sv
`default_nettype none

`include "regfile_cfg.svh"

module apb_regfile_slave (
    input  rf_bus_pkg::apb_req_t      apb_req,
    output rf_bus_pkg::apb_rsp_t      apb_rsp,
    output rf_arch_pkg::gpr_wr_req_t  wr_req,
    output rf_arch_pkg::gpr_rd_req_t  rd_req,
    input  rf_arch_pkg::gpr_word_t    rd_data
);

    // address layout: id in the low bits, size above it, the rest must be zero
    localparam int ID_W = $bits(rf_arch_pkg::reg_id_t);
    localparam int SZ_W = $bits(rf_arch_pkg::op_size_e);
    localparam int UP_LSB = ID_W + SZ_W;

    logic                  access;
    rf_arch_pkg::reg_id_t  addr_id;
    rf_arch_pkg::op_size_e addr_size;
    logic                  upper_set;
    logic                  bad_xfer;
    logic                  rd_ok;

    // second cycle of a transfer, slave answers here with no wait states
    assign access = apb_req.psel && apb_req.penable;

    // field split of paddr
    assign addr_id   = apb_req.paddr[ID_W-1:0];
    assign addr_size = rf_arch_pkg::op_size_e'(apb_req.paddr[UP_LSB-1:ID_W]);
    assign upper_set = |apb_req.paddr[`RF_APB_ADDR_W-1:UP_LSB];

    // illegal size or stray upper address bits
    assign bad_xfer = (addr_size == rf_arch_pkg::SIZE_BAD) || upper_set;

    // only a clean read returns register data
    assign rd_ok = access && !apb_req.pwrite && !bad_xfer;

    always_comb begin
        apb_rsp.pready  = access;
        apb_rsp.pslverr = access && bad_xfer;
        apb_rsp.prdata  = rd_ok ? rd_data : '0;
    end

    // write lands on the completing edge, errored writes are dropped
    always_comb begin
        wr_req.valid = access && apb_req.pwrite && !bad_xfer;
        wr_req.id    = addr_id;
        wr_req.size  = addr_size;
        wr_req.data  = apb_req.pwdata;
    end

    // read port follows the address directly
    always_comb begin
        rd_req.id   = addr_id;
        rd_req.size = addr_size;
    end

endmodule

`default_nettype wire

//--- rtl/gpr_array.sv
`default_nettype none

`include "regfile_cfg.svh"

module gpr_array (
    input  logic                      clk,
    input  logic                      rst_n,
    input  rf_arch_pkg::gpr_wr_req_t  wr_req,
    input  rf_arch_pkg::gpr_rd_req_t  rd_req,
    output rf_arch_pkg::gpr_word_t    rd_data
);

    localparam int ID_W  = $bits(rf_arch_pkg::reg_id_t);
    localparam int LANES = `RF_DATA_W / 8;

    // the eight architectural registers
    rf_arch_pkg::gpr_word_t regs [`RF_NUM_REGS];

    // decoder outputs for the write port
    rf_arch_pkg::lane_en_t lane_en;
    logic                  sh;

    // write data after the high byte shift
    rf_arch_pkg::gpr_word_t wr_data;

    // lane enables regrouped per register, lane 0 is bits 7..0
    logic [LANES-1:0] reg_lanes [`RF_NUM_REGS];

    // read side
    logic                   rd_hi;
    rf_arch_pkg::reg_id_t   rd_idx;
    rf_arch_pkg::gpr_word_t rd_word;

    register_file_decoder u_decoder (
        .id      (wr_req.id),
        .size    (wr_req.size),
        .lane_en (lane_en),
        .sh      (sh)
    );

    // ah..bh writes carry the byte low, so move it up to byte 1
    assign wr_data = sh ? (wr_req.data << 8) : wr_req.data;

    always_comb begin
        for (int n = 0; n < `RF_NUM_REGS; n++) begin
            reg_lanes[n] = {lane_en.hh[n], lane_en.hl[n], lane_en.lh[n], lane_en.ll[n]};
        end
    end

    // byte lane writes, untouched lanes keep their value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int n = 0; n < `RF_NUM_REGS; n++) begin
                regs[n] <= '0;
            end
        end else if (wr_req.valid) begin
            for (int n = 0; n < `RF_NUM_REGS; n++) begin
                for (int b = 0; b < LANES; b++) begin
                    if (reg_lanes[n][b]) begin
                        regs[n][8*b +: 8] <= wr_data[8*b +: 8];
                    end
                end
            end
        end
    end

    // byte read of ids 4..7 names byte 1 of registers 0..3
    assign rd_hi  = (rd_req.size == rf_arch_pkg::SIZE_BYTE) && rd_req.id[ID_W-1];
    assign rd_idx = rd_hi ? {1'b0, rd_req.id[ID_W-2:0]} : rd_req.id;

    assign rd_word = regs[rd_idx];

    // size alignment, narrow results are zero extended
    always_comb begin
        case (rd_req.size)
            rf_arch_pkg::SIZE_BYTE: begin
                if (rd_hi) begin
                    rd_data = {{(`RF_DATA_W-8){1'b0}}, rd_word[15:8]};
                end else begin
                    rd_data = {{(`RF_DATA_W-8){1'b0}}, rd_word[7:0]};
                end
            end
            rf_arch_pkg::SIZE_WORD: begin
                rd_data = {{(`RF_DATA_W-16){1'b0}}, rd_word[15:0]};
            end
            rf_arch_pkg::SIZE_DWORD: begin
                rd_data = rd_word;
            end
            default: begin
                // illegal size reads as zero
                rd_data = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/regfile_cfg.svh
`ifndef REGFILE_CFG_SVH
`define REGFILE_CFG_SVH

// architectural general purpose registers
// eax ecx edx ebx esp ebp esi edi in x86 id order
`define RF_NUM_REGS 8

// register width, also the apb data bus width
`define RF_DATA_W 32

// apb address bus width
// bits 2..0 carry the register id, bits 4..3 the operand size
// everything above must be zero or the transfer errors
`define RF_APB_ADDR_W 8

`endif

//--- rtl/register_file_decoder.sv
`default_nettype none

`include "regfile_cfg.svh"

module register_file_decoder (
    input  rf_arch_pkg::reg_id_t   id,
    input  rf_arch_pkg::op_size_e  size,
    output rf_arch_pkg::lane_en_t  lane_en,
    output logic                   sh
);

    localparam int ID_W = $bits(rf_arch_pkg::reg_id_t);

    // size classes
    logic is_byte;
    logic is_word;
    logic is_dword;

    // byte write aimed at ah ch dh bh
    logic hi_byte;
    // register that actually holds the high byte, id minus 4
    rf_arch_pkg::reg_id_t hi_reg;

    // one hot of the named register and of the high byte alias
    logic [`RF_NUM_REGS-1:0] id_oh;
    logic [`RF_NUM_REGS-1:0] hi_oh;

    assign is_byte  = (size == rf_arch_pkg::SIZE_BYTE);
    assign is_word  = (size == rf_arch_pkg::SIZE_WORD);
    assign is_dword = (size == rf_arch_pkg::SIZE_DWORD);

    // ids 4..7 have the top id bit set
    assign hi_byte = is_byte && id[ID_W-1];
    assign hi_reg  = {1'b0, id[ID_W-2:0]};

    always_comb begin
        for (int n = 0; n < `RF_NUM_REGS; n++) begin
            id_oh[n] = (id == rf_arch_pkg::reg_id_t'(n));
            hi_oh[n] = (hi_reg == rf_arch_pkg::reg_id_t'(n));
        end
    end

    always_comb begin
        lane_en = '0;

        // upper half only on a full dword write
        if (is_dword) begin
            lane_en.hh = id_oh;
            lane_en.hl = id_oh;
        end

        // byte 1 on word or dword of the named register
        // or on a byte write of ah..bh, landing in eax..ebx
        if (is_word || is_dword) begin
            lane_en.lh = id_oh;
        end else if (hi_byte) begin
            lane_en.lh = hi_oh;
        end

        // byte 0 on word or dword, and on al..bl byte writes
        if (is_word || is_dword || (is_byte && !hi_byte)) begin
            lane_en.ll = id_oh;
        end

        // SIZE_BAD falls through with no lane set
    end

    // write data for ah..bh arrives in bits 7..0 and must move to 15..8
    assign sh = hi_byte;

endmodule

`default_nettype wire

//--- rtl/rf_arch_pkg.sv
`default_nettype none

`include "regfile_cfg.svh"

package rf_arch_pkg;

    // register id as the x86 reg field encodes it
    // byte ops reuse ids 4..7 for ah ch dh bh
    typedef logic [$clog2(`RF_NUM_REGS)-1:0] reg_id_t;

    // operand size of a register access
    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_WORD  = 2'd1,
        SIZE_DWORD = 2'd2,
        SIZE_BAD   = 2'd3
    } op_size_e;

    // one full register value
    typedef logic [`RF_DATA_W-1:0] gpr_word_t;

    // per register byte lane enables
    // bit n of each vector enables that lane of register n
    typedef struct packed {
        logic [`RF_NUM_REGS-1:0] hh;  // bits 31..24
        logic [`RF_NUM_REGS-1:0] hl;  // bits 23..16
        logic [`RF_NUM_REGS-1:0] lh;  // bits 15..8
        logic [`RF_NUM_REGS-1:0] ll;  // bits 7..0
    } lane_en_t;

    // write port request, data is low aligned
    typedef struct packed {
        logic      valid;
        reg_id_t   id;
        op_size_e  size;
        gpr_word_t data;
    } gpr_wr_req_t;

    // read port request
    typedef struct packed {
        reg_id_t  id;
        op_size_e size;
    } gpr_rd_req_t;

endpackage

`default_nettype wire

//--- rtl/rf_bus_pkg.sv
`default_nettype none

`include "regfile_cfg.svh"

package rf_bus_pkg;

    // apb master to slave signals
    // single slave so psel is a plain bit
    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [`RF_APB_ADDR_W-1:0] paddr;
        logic [`RF_DATA_W-1:0]     pwdata;
    } apb_req_t;

    // apb slave to master signals
    // no wait states, pready only marks the access phase
    typedef struct packed {
        logic                  pready;
        logic                  pslverr;
        logic [`RF_DATA_W-1:0] prdata;
    } apb_rsp_t;

endpackage

`default_nettype wire

//--- rtl/x86_regfile.sv
`default_nettype none

`include "regfile_cfg.svh"

module x86_regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rf_bus_pkg::apb_req_t  apb_req,
    output rf_bus_pkg::apb_rsp_t  apb_rsp
);

    // slave to array request and read return
    rf_arch_pkg::gpr_wr_req_t wr_req;
    rf_arch_pkg::gpr_rd_req_t rd_req;
    rf_arch_pkg::gpr_word_t   rd_data;

    // apb decode and error checks, purely combinational
    apb_regfile_slave u_apb_slave (
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .wr_req  (wr_req),
        .rd_req  (rd_req),
        .rd_data (rd_data)
    );

    // register storage, byte lane writes and aligned reads
    gpr_array u_gpr_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_req  (wr_req),
        .rd_req  (rd_req),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

//--- verif/x86_regfile_checker.sv
`default_nettype none

`include "regfile_cfg.svh"

module x86_regfile_checker (
    input logic                      clk,
    input logic                      rst_n,
    input rf_bus_pkg::apb_req_t      apb_req,
    input rf_bus_pkg::apb_rsp_t      apb_rsp,
    input rf_arch_pkg::gpr_wr_req_t  wr_req,
    input rf_arch_pkg::lane_en_t     lane_en,
    input logic                      sh
);

    // number of assertion failures so far
    int fail_count = 0;

    // registers with any byte lane enabled by the decoder
    logic [`RF_NUM_REGS-1:0] reg_hit;

    assign reg_hit = lane_en.hh | lane_en.hl | lane_en.lh | lane_en.ll;

    // pready only in the access phase
    ready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        apb_rsp.pready |-> (apb_req.psel && apb_req.penable))
    else begin
        $error("pready high outside an apb access phase");
        fail_count = fail_count + 1;
    end

    // an error response is always a completed transfer
    err_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
        apb_rsp.pslverr |-> apb_rsp.pready)
    else begin
        $error("pslverr high without pready");
        fail_count = fail_count + 1;
    end

    // one write names one register, ah..bh included
    one_reg_lanes: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(reg_hit))
    else begin
        $error("byte lanes enabled in more than one register");
        fail_count = fail_count + 1;
    end

    // the high byte shift exists only for byte writes
    shift_on_byte: assert property (@(posedge clk) disable iff (!rst_n)
        sh |-> (wr_req.size == rf_arch_pkg::SIZE_BYTE))
    else begin
        $error("high byte shift set for a non byte write");
        fail_count = fail_count + 1;
    end

endmodule

// sits in the top level, decoder outputs come from the array below it
bind x86_regfile x86_regfile_checker u_checker (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .wr_req  (wr_req),
    .lane_en (u_gpr_array.lane_en),
    .sh      (u_gpr_array.sh)
);

`default_nettype wire

//--- verif/x86_regfile_tb.sv
`default_nettype none

`include "regfile_cfg.svh"

module x86_regfile_tb;

    localparam int UP_W         = `RF_APB_ADDR_W - 5;
    localparam int RANDOM_XFERS = 40;

    // one apb transfer and the response the register model expects
    typedef struct packed {
        logic                   wr;
        rf_arch_pkg::op_size_e  size;
        rf_arch_pkg::reg_id_t   id;
        logic [UP_W-1:0]        upper;
        rf_arch_pkg::gpr_word_t wdata;
        rf_arch_pkg::gpr_word_t exp_data;
        logic                   exp_err;
    } xfer_t;

    logic                 clk;
    logic                 rst_n;
    rf_bus_pkg::apb_req_t apb_req;
    rf_bus_pkg::apb_rsp_t apb_rsp;

    // shadow copy of eax..edi, updated while the table is built
    rf_arch_pkg::gpr_word_t shadow [`RF_NUM_REGS];
    xfer_t                  xfers [$];

    int     data_errs;
    int     err_errs;
    int     ready_errs;
    int     cycles = 0;
    int     cycle_limit;
    int     cur_idx;
    integer seed;

    x86_regfile x86_regfile_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // run limit, three cycles per transfer plus slack
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the transfers never finished", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic rf_arch_pkg::op_size_e to_size(int s);
        return rf_arch_pkg::op_size_e'(2'(s));
    endfunction

    function automatic rf_arch_pkg::reg_id_t to_id(int i);
        return rf_arch_pkg::reg_id_t'(i);
    endfunction

    // register update by x86 naming, ids 4..7 of a byte op are ah ch dh bh
    task automatic model_write(input rf_arch_pkg::op_size_e size, input rf_arch_pkg::reg_id_t id,
                               input rf_arch_pkg::gpr_word_t data);
        rf_arch_pkg::reg_id_t base;
        base = id - 3'd4;
        case (size)
            rf_arch_pkg::SIZE_BYTE: begin
                if (id < 3'd4) begin
                    shadow[id][7:0] = data[7:0];
                end else begin
                    shadow[base][15:8] = data[7:0];
                end
            end
            rf_arch_pkg::SIZE_WORD: begin
                shadow[id][15:0] = data[15:0];
            end
            rf_arch_pkg::SIZE_DWORD: begin
                shadow[id] = data;
            end
            default: begin
                // size 3 writes nothing
            end
        endcase
    endtask

    // narrow reads come back zero extended
    function automatic rf_arch_pkg::gpr_word_t model_read(input rf_arch_pkg::op_size_e size,
                                                          input rf_arch_pkg::reg_id_t id);
        rf_arch_pkg::reg_id_t   base;
        rf_arch_pkg::gpr_word_t val;
        base = id - 3'd4;
        val  = '0;
        case (size)
            rf_arch_pkg::SIZE_BYTE: begin
                if (id < 3'd4) begin
                    val[7:0] = shadow[id][7:0];
                end else begin
                    val[7:0] = shadow[base][15:8];
                end
            end
            rf_arch_pkg::SIZE_WORD: begin
                val[15:0] = shadow[id][15:0];
            end
            rf_arch_pkg::SIZE_DWORD: begin
                val = shadow[id];
            end
            default: begin
                val = '0;
            end
        endcase
        return val;
    endfunction

    // append a transfer, expected response from the shadow model
    task automatic add_xfer(input logic wr, input rf_arch_pkg::op_size_e size,
                            input rf_arch_pkg::reg_id_t id, input logic [UP_W-1:0] upper,
                            input rf_arch_pkg::gpr_word_t wdata);
        xfer_t v;
        v.wr       = wr;
        v.size     = size;
        v.id       = id;
        v.upper    = upper;
        v.wdata    = wdata;
        v.exp_err  = (size == rf_arch_pkg::SIZE_BAD) || (upper != '0);
        // writes and errored reads return zero data
        v.exp_data = '0;
        if (!v.exp_err) begin
            if (wr) begin
                model_write(size, id, wdata);
            end else begin
                v.exp_data = model_read(size, id);
            end
        end
        xfers.push_back(v);
    endtask

    task automatic build_table();
        rf_arch_pkg::gpr_word_t rnd_a;
        rf_arch_pkg::gpr_word_t rnd_b;
        for (int n = 0; n < `RF_NUM_REGS; n++) begin
            shadow[n] = '0;
        end
        // reset value at byte, word and dword size
        for (int s = 0; s < 3; s++) begin
            for (int i = 0; i < 8; i++) begin
                add_xfer(1'b0, to_size(s), to_id(i), '0, '0);
            end
        end
        // full writes, then dword and word reads
        for (int i = 0; i < 8; i++) begin
            add_xfer(1'b1, rf_arch_pkg::SIZE_DWORD, to_id(i), '0, 32'h9e37_79b9 * 32'(i + 1));
        end
        for (int s = 2; s > 0; s--) begin
            for (int i = 0; i < 8; i++) begin
                add_xfer(1'b0, to_size(s), to_id(i), '0, '0);
            end
        end
        // al..bl, junk above bit 7 must not land
        for (int i = 0; i < 4; i++) begin
            add_xfer(1'b1, rf_arch_pkg::SIZE_BYTE, to_id(i), '0, 32'hffff_ff30 + 32'(i));
        end
        for (int i = 0; i < 4; i++) begin
            add_xfer(1'b0, rf_arch_pkg::SIZE_DWORD, to_id(i), '0, '0);
        end
        // ah..bh land in byte 1 of eax..ebx
        for (int i = 4; i < 8; i++) begin
            add_xfer(1'b1, rf_arch_pkg::SIZE_BYTE, to_id(i), '0, 32'heeee_ee40 + 32'(i));
        end
        for (int s = 0; s < 3; s += 2) begin
            for (int i = 7; i >= 0; i--) begin
                add_xfer(1'b0, to_size(s), to_id(i), '0, '0);
            end
        end
        // word writes keep the upper half
        for (int i = 0; i < 8; i++) begin
            add_xfer(1'b1, rf_arch_pkg::SIZE_WORD, to_id(i), '0, 32'hcccc_0000 + 32'(i * 257));
        end
        for (int i = 0; i < 8; i++) begin
            add_xfer(1'b0, rf_arch_pkg::SIZE_DWORD, to_id(i), '0, '0);
        end
        // illegal size and stray upper address bits
        add_xfer(1'b1, rf_arch_pkg::SIZE_BAD, to_id(2), '0, 32'h1234_5678);
        add_xfer(1'b1, rf_arch_pkg::SIZE_DWORD, to_id(5), UP_W'(1), 32'h8765_4321);
        add_xfer(1'b1, rf_arch_pkg::SIZE_BYTE, to_id(6), UP_W'(4), 32'h0000_00aa);
        add_xfer(1'b0, rf_arch_pkg::SIZE_BAD, to_id(1), '0, '0);
        add_xfer(1'b0, rf_arch_pkg::SIZE_DWORD, to_id(0), UP_W'(2), '0);
        for (int i = 0; i < 8; i++) begin
            add_xfer(1'b0, rf_arch_pkg::SIZE_DWORD, to_id(i), '0, '0);
        end
        // random legal mix of reads and writes
        for (int k = 0; k < RANDOM_XFERS; k++) begin
            rnd_a = $random(seed);
            rnd_b = $random(seed);
            add_xfer(rnd_a[0], to_size(int'(rnd_a[5:4]) % 3), rnd_a[10:8], '0, rnd_b);
        end
    endtask

    task automatic check_data(input rf_arch_pkg::gpr_word_t exp,
                              input rf_arch_pkg::gpr_word_t act);
        if (act !== exp) begin
            $display("Fail prdata xfer %0d: expected %h, got %h", cur_idx, exp, act);
            data_errs++;
        end
    endtask

    task automatic check_err(input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail pslverr xfer %0d: expected %h, got %h", cur_idx, exp, act);
            err_errs++;
        end
    endtask

    task automatic check_ready(input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail pready xfer %0d: expected %h, got %h", cur_idx, exp, act);
            ready_errs++;
        end
    endtask

    // setup then access, called and returning 1 unit after a rising edge
    task automatic run_xfer(input xfer_t v);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = v.wr;
        apb_req.paddr   = {v.upper, v.size, v.id};
        apb_req.pwdata  = v.wdata;
        @(negedge clk);
        // no response during setup
        check_ready(1'b0, apb_rsp.pready);
        check_err(1'b0, apb_rsp.pslverr);
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);
        while (!apb_rsp.pready) begin
            @(negedge clk);
        end
        check_data(v.exp_data, apb_rsp.prdata);
        check_err(v.exp_err, apb_rsp.pslverr);
        // completing edge
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    initial begin
        int asserts;
        int total;
        apb_req    = '0;
        rst_n      = 1'b0;
        data_errs  = 0;
        err_errs   = 0;
        ready_errs = 0;
        cur_idx    = -1;
        seed       = 32'h8efb7c80;
        build_table();
        cycle_limit = 3 * xfers.size() + 50;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // idle bus after reset
        repeat (2) begin
            @(negedge clk);
            check_ready(1'b0, apb_rsp.pready);
            check_err(1'b0, apb_rsp.pslverr);
        end
        @(posedge clk);
        #1;
        for (int i = 0; i < xfers.size(); i++) begin
            cur_idx = i;
            run_xfer(xfers[i]);
        end
        asserts = x86_regfile_inst.u_checker.fail_count;
        total   = data_errs + err_errs + ready_errs + asserts;
        $display("%0d transfers, errors: prdata %0d, pslverr %0d, pready %0d, assertions %0d",
                 xfers.size(), data_errs, err_errs, ready_errs, asserts);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- x86_regfile.f
+incdir+rtl
rtl/rf_arch_pkg.sv
rtl/rf_bus_pkg.sv
rtl/register_file_decoder.sv
rtl/gpr_array.sv
rtl/apb_regfile_slave.sv
rtl/x86_regfile.sv
verif/x86_regfile_checker.sv
verif/x86_regfile_tb.sv
